// ==== clock_pkg.sv ====
// Shared types and constants for the 12-hour wall clock.
// Holds the BCD time record, the setup field and FSM enums,
// the button pulse bundle, the segment array and the digit limits.

`default_nettype none

package clock_pkg;

    // Six BCD digits, tens of hours in the top nibble.
    typedef struct packed {
        logic [3:0] h1;
        logic [3:0] h0;
        logic [3:0] m1;
        logic [3:0] m0;
        logic [3:0] s1;
        logic [3:0] s0;
    } time_bcd_t;

    typedef enum logic [1:0] {
        FIELD_HR  = 2'd0,
        FIELD_MIN = 2'd1,
        FIELD_SEC = 2'd2
    } field_e;

    typedef enum logic [1:0] {
        ST_INIT  = 2'd0,
        ST_RUN   = 2'd1,
        ST_SETUP = 2'd2
    } clock_state_e;

    // One-cycle pulses out of the input synchronizer.
    typedef struct packed {
        logic adjust;
        logic mode;
        logic toggle;
        logic tick;
    } button_pulse_t;

    // Index 5 drives the tens-of-hours digit, index 0 the seconds units.
    // Patterns are active high with segment a in bit 0.
    typedef logic [5:0][6:0] segments_t;

    localparam logic [6:0] SEG_BLANK = 7'h00;

    localparam logic [3:0] MAX_HOUR_TENS         = 4'd1;
    localparam logic [3:0] MAX_HOUR_UNITS_AT_TEN = 4'd2; // units limit once the tens read 1.
    localparam logic [3:0] MAX_MIN_TENS          = 4'd5;
    localparam logic [3:0] MAX_SEC_TENS          = 4'd5;

    localparam time_bcd_t RESET_TIME = '{
        h1: 4'd1,
        h0: 4'd2,
        m1: 4'd0,
        m0: 4'd0,
        s1: 4'd0,
        s0: 4'd0
    };

endpackage

`default_nettype wire

// ==== input_sync.sv ====
// Input conditioning for the three push-buttons and the 1 Hz square wave.
// Two-flop synchronizers, a previous-value flop and registered
// rising-edge pulses, one bit per input.

`default_nettype none

module input_sync (
    input  logic                     CLK_50,
    input  logic                     reset,
    input  logic                     adjust,
    input  logic                     mode,
    input  logic                     toggle,
    input  logic                     clk_1hz,
    output clock_pkg::button_pulse_t pulses
);

    logic [3:0] raw;        // same bit order as the pulse struct.
    logic [3:0] sync_1;
    logic [3:0] sync_2;
    logic [3:0] prev;
    logic [3:0] pulse_bits;

    assign raw = {adjust, mode, toggle, clk_1hz};

    always_ff @(posedge CLK_50) begin
        if (reset) begin
            sync_1 <= 4'b0000;
            sync_2 <= 4'b0000;
            prev   <= 4'b0000;
            pulses <= '0;
        end else begin
            sync_1 <= raw;               // first stage may go metastable.
            sync_2 <= sync_1;
            prev   <= sync_2;
            pulses <= sync_2 & ~prev;    // high only on the cycle after a rise.
        end
    end

    assign pulse_bits = pulses;

    // Raw levels stay high and low for at least 4 cycles each, so two
    // pulses of one input are at least 8 cycles apart.
    a_pulse_spacing: assert property (
        @(posedge CLK_50) disable iff (reset)
        (pulse_bits & ($past(pulse_bits, 1) | $past(pulse_bits, 2) | $past(pulse_bits, 3) |
                       $past(pulse_bits, 4) | $past(pulse_bits, 5) | $past(pulse_bits, 6) |
                       $past(pulse_bits, 7))) == 4'b0000
    );

endmodule

`default_nettype wire

// ==== field_select.sv ====
// Setup field selector.
// Rotates hours, minutes, seconds on mode pulses while the clock is
// being set and falls back to hours as soon as setup ends.

`default_nettype none

module field_select (
    input  logic              CLK_50,
    input  logic              reset,
    input  logic              setting,
    input  logic              mode_pulse,
    output clock_pkg::field_e field
);

    import clock_pkg::*;

    field_e field_q;

    always_ff @(posedge CLK_50) begin
        if (reset) begin
            field_q <= FIELD_HR;
        end else if (!setting) begin
            field_q <= FIELD_HR;           // every setup session starts on hours.
        end else if (mode_pulse) begin
            case (field_q)
                FIELD_HR:  field_q <= FIELD_MIN;
                FIELD_MIN: field_q <= FIELD_SEC;
                default:   field_q <= FIELD_HR;
            endcase
        end
    end

    // Outside setup the output reads hours at once, even in the cycle
    // where the register is still being cleared.
    assign field = setting ? field_q : FIELD_HR;

    a_field_legal: assert property (
        @(posedge CLK_50) disable iff (reset)
        field inside {FIELD_HR, FIELD_MIN, FIELD_SEC}
    );

endmodule

`default_nettype wire

// ==== time_keeper.sv ====
// Time keeping core of the clock.
// Run/setup FSM, the six BCD time registers with the seconds to
// minutes to hours carry chain, and the rules for setting each field.

`default_nettype none

module time_keeper (
    input  logic                     CLK_50,
    input  logic                     reset,
    input  clock_pkg::button_pulse_t pulses,
    input  clock_pkg::field_e        field,
    output logic                     setting,
    output clock_pkg::time_bcd_t     cur_time
);

    import clock_pkg::*;

    clock_state_e state;
    clock_state_e state_next;
    time_bcd_t    time_next;
    logic         sec_wrap;
    logic         min_wrap;

    // Counts a two-digit BCD field through 00..(max_tens)9 and back to 00.
    function automatic logic [7:0] next_sixty(
        input logic [3:0] tens,
        input logic [3:0] units,
        input logic [3:0] max_tens
    );
        logic [7:0] result;
        if (units == 4'd9) begin
            if (tens == max_tens) begin
                result = 8'h00;
            end else begin
                result = {tens + 4'd1, 4'd0};
            end
        end else begin
            result = {tens, units + 4'd1};
        end
        return result;
    endfunction

    // Hour runs 1..12, there is no zero hour.
    function automatic logic [7:0] next_hour(
        input logic [3:0] h1,
        input logic [3:0] h0
    );
        logic [7:0] result;
        if (h1 == MAX_HOUR_TENS && h0 == MAX_HOUR_UNITS_AT_TEN) begin
            result = {4'd0, 4'd1};
        end else if (h0 == 4'd9) begin
            result = {h1 + 4'd1, 4'd0};
        end else begin
            result = {h1, h0 + 4'd1};
        end
        return result;
    endfunction

    assign sec_wrap = (cur_time.s1 == MAX_SEC_TENS) && (cur_time.s0 == 4'd9);
    assign min_wrap = (cur_time.m1 == MAX_MIN_TENS) && (cur_time.m0 == 4'd9);
    assign setting  = (state == ST_SETUP);

    always_comb begin
        case (state)
            ST_INIT:  state_next = ST_RUN;
            ST_RUN:   state_next = pulses.adjust ? ST_SETUP : ST_RUN;
            ST_SETUP: state_next = pulses.adjust ? ST_RUN : ST_SETUP;
            default:  state_next = ST_INIT;
        endcase
    end

    always_comb begin
        time_next = cur_time;
        if (state == ST_RUN && pulses.tick) begin
            {time_next.s1, time_next.s0} = next_sixty(cur_time.s1, cur_time.s0,
                                                      MAX_SEC_TENS);
            if (sec_wrap) begin
                {time_next.m1, time_next.m0} = next_sixty(cur_time.m1, cur_time.m0,
                                                          MAX_MIN_TENS);
                if (min_wrap) begin
                    {time_next.h1, time_next.h0} = next_hour(cur_time.h1, cur_time.h0);
                end
            end
        end else if (state == ST_SETUP && pulses.toggle) begin
            case (field)
                FIELD_SEC: begin
                    time_next.s1 = 4'd0;
                    time_next.s0 = 4'd0;
                end
                FIELD_MIN: begin
                    // Minutes wrap on their own here, the hour is left alone.
                    {time_next.m1, time_next.m0} = next_sixty(cur_time.m1, cur_time.m0,
                                                              MAX_MIN_TENS);
                end
                default: begin
                    {time_next.h1, time_next.h0} = next_hour(cur_time.h1, cur_time.h0);
                end
            endcase
        end
    end

    always_ff @(posedge CLK_50) begin
        if (reset) begin
            state    <= ST_INIT;
            cur_time <= RESET_TIME;
        end else begin
            state    <= state_next;
            cur_time <= time_next;
        end
    end

    a_digits_in_range: assert property (
        @(posedge CLK_50) disable iff (reset)
        cur_time.s0 <= 4'd9 && cur_time.s1 <= MAX_SEC_TENS &&
        cur_time.m0 <= 4'd9 && cur_time.m1 <= MAX_MIN_TENS &&
        cur_time.h0 <= 4'd9 && cur_time.h1 <= MAX_HOUR_TENS
    );

    a_hour_legal: assert property (
        @(posedge CLK_50) disable iff (reset)
        {cur_time.h1, cur_time.h0} != 8'h00 &&
        (cur_time.h1 < MAX_HOUR_TENS || cur_time.h0 <= MAX_HOUR_UNITS_AT_TEN)
    );

    // Ticks arriving in setup must not move the time.
    a_setup_holds_time: assert property (
        @(posedge CLK_50) disable iff (reset)
        (state == ST_SETUP && !pulses.toggle) |=> $stable(cur_time)
    );

endmodule

`default_nettype wire

// ==== digit_display.sv ====
// Seven-segment output stage for the six clock digits.
// Decodes each BCD digit, blanks a leading zero in the tens of hours
// and registers the whole pattern.

`default_nettype none

module digit_display (
    input  logic                 CLK_50,
    input  logic                 reset,
    input  clock_pkg::time_bcd_t cur_time,
    output clock_pkg::segments_t segments
);

    import clock_pkg::*;

    logic [5:0][3:0] digits;     // digits[5] is the tens of hours.
    segments_t       seg_next;

    // Active high, segment a in bit 0, g in bit 6.
    function automatic logic [6:0] seg7(input logic [3:0] digit);
        logic [6:0] pattern;
        case (digit)
            4'd0:    pattern = 7'h3F;
            4'd1:    pattern = 7'h06;
            4'd2:    pattern = 7'h5B;
            4'd3:    pattern = 7'h4F;
            4'd4:    pattern = 7'h66;
            4'd5:    pattern = 7'h6D;
            4'd6:    pattern = 7'h7D;
            4'd7:    pattern = 7'h07;
            4'd8:    pattern = 7'h7F;
            4'd9:    pattern = 7'h6F;
            default: pattern = SEG_BLANK;
        endcase
        return pattern;
    endfunction

    assign digits = cur_time;

    always_comb begin
        for (int i = 0; i < 6; i++) begin
            seg_next[i] = seg7(digits[i]);
        end
        if (digits[5] == 4'd0) begin
            seg_next[5] = SEG_BLANK;     // single-digit hours show no leading zero.
        end
    end

    always_ff @(posedge CLK_50) begin
        if (reset) begin
            segments <= {6{SEG_BLANK}};  // dark for the reset cycles.
        end else begin
            segments <= seg_next;
        end
    end

endmodule

`default_nettype wire

// ==== clock_top.sv ====
// Top level of the 12-hour wall clock.
// Connects the input synchronizer, the field selector, the time keeper
// and the seven-segment display stage.

`default_nettype none

module clock_top (
    input  logic                 CLK_50,
    input  logic                 reset,
    input  logic                 adjust,
    input  logic                 mode,
    input  logic                 toggle,
    input  logic                 clk_1hz,
    output clock_pkg::time_bcd_t cur_time,
    output clock_pkg::field_e    field,
    output logic                 setting,
    output clock_pkg::segments_t segments
);

    import clock_pkg::*;

    button_pulse_t pulses;

    input_sync sync_i (
        .CLK_50  (CLK_50),
        .reset   (reset),
        .adjust  (adjust),
        .mode    (mode),
        .toggle  (toggle),
        .clk_1hz (clk_1hz),
        .pulses  (pulses)
    );

    field_select select_i (
        .CLK_50     (CLK_50),
        .reset      (reset),
        .setting    (setting),
        .mode_pulse (pulses.mode),
        .field      (field)
    );

    time_keeper keeper_i (
        .CLK_50   (CLK_50),
        .reset    (reset),
        .pulses   (pulses),
        .field    (field),
        .setting  (setting),
        .cur_time (cur_time)
    );

    digit_display display_i (
        .CLK_50   (CLK_50),
        .reset    (reset),
        .cur_time (cur_time),
        .segments (segments)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
// Self-checking testbench for the 12-hour wall clock.
// Button and 1 Hz stimulus, LFSR event picker, reference model of
// time, field and segments, and typed compare tasks.

`default_nettype none

module tb_clock;

    import clock_pkg::*;

    typedef enum logic [1:0] {EV_TICK, EV_TOGGLE, EV_MODE, EV_ADJUST} event_e;

    localparam int SETTLE_CYCLES = 8;
    localparam int ACK_TIMEOUT   = 16;
    localparam logic [6:0] SEG_TABLE [10] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66,
                                               7'h6D, 7'h7D, 7'h07, 7'h7F, 7'h6F};
    localparam field_e FIELD_SEQ [4] = '{FIELD_MIN, FIELD_SEC, FIELD_HR, FIELD_MIN};

    logic        CLK_50 = 1'b0;
    logic        reset;
    logic        adjust;
    logic        mode;
    logic        toggle;
    logic        clk_1hz;
    time_bcd_t   cur_time;
    field_e      field;
    logic        setting;
    segments_t   segments;

    time_bcd_t   m_time;               // model of the time registers.
    field_e      m_field;
    logic        m_setting;
    logic [15:0] lfsr = 16'd64;
    int          req_count = 0;        // compare requests from the stimulus.
    int          ack_count = 0;        // requests served by the compare process.

    always #4 CLK_50 = ~CLK_50;

    clock_top dut_i (
        .CLK_50   (CLK_50),
        .reset    (reset),
        .adjust   (adjust),
        .mode     (mode),
        .toggle   (toggle),
        .clk_1hz  (clk_1hz),
        .cur_time (cur_time),
        .field    (field),
        .setting  (setting),
        .segments (segments)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_time(input time_bcd_t exp, input time_bcd_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %0t cur_time expected %h actual %h", $time, exp, act));
        end
    endtask

    task automatic check_field(input field_e exp, input field_e act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %0t field expected %s actual %s",
                               $time, exp.name(), act.name()));
        end
    endtask

    task automatic check_setting(input logic exp, input logic act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %0t setting expected %b actual %b", $time, exp, act));
        end
    endtask

    task automatic check_segments(input segments_t exp, input segments_t act);
        if (act !== exp) begin
            fail_run($sformatf("ERR %0t segments expected %h actual %h", $time, exp, act));
        end
    endtask

    // Works in plain seconds, minutes and hours rather than BCD digits.
    function automatic time_bcd_t next_time(input time_bcd_t t, input logic in_setup,
                                            input field_e fld, input event_e ev);
        int        hr;
        int        mn;
        int        sc;
        time_bcd_t r;
        hr = int'(t.h1) * 10 + int'(t.h0);
        mn = int'(t.m1) * 10 + int'(t.m0);
        sc = int'(t.s1) * 10 + int'(t.s0);
        if (ev == EV_TICK && !in_setup) begin
            sc = sc + 1;
            if (sc == 60) begin
                sc = 0;
                mn = mn + 1;
            end
            if (mn == 60) begin
                mn = 0;
                hr = hr % 12 + 1;          // 12 is followed by 1.
            end
        end else if (ev == EV_TOGGLE && in_setup) begin
            case (fld)
                FIELD_HR:  hr = hr % 12 + 1;
                FIELD_MIN: mn = (mn + 1) % 60;
                default:   sc = 0;
            endcase
        end
        r.h1 = 4'(hr / 10);
        r.h0 = 4'(hr % 10);
        r.m1 = 4'(mn / 10);
        r.m0 = 4'(mn % 10);
        r.s1 = 4'(sc / 10);
        r.s0 = 4'(sc % 10);
        return r;
    endfunction

    function automatic field_e next_field(input field_e f);
        case (f)
            FIELD_HR:  return FIELD_MIN;
            FIELD_MIN: return FIELD_SEC;
            default:   return FIELD_HR;
        endcase
    endfunction

    function automatic segments_t seg_ref(input time_bcd_t t);
        segments_t s;
        s[5] = (t.h1 == 4'd0) ? SEG_BLANK : SEG_TABLE[t.h1];
        s[4] = SEG_TABLE[t.h0];
        s[3] = SEG_TABLE[t.m1];
        s[2] = SEG_TABLE[t.m0];
        s[1] = SEG_TABLE[t.s1];
        s[0] = SEG_TABLE[t.s0];
        return s;
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic pick_event(output event_e ev);
        logic [1:0] bits;
        for (int b = 0; b < 2; b++) begin
            lfsr = lfsr_next(lfsr);
            bits[b] = lfsr[0];
        end
        ev = event_e'(bits);
    endtask

    task automatic drive_input(input event_e ev, input logic level);
        case (ev)
            EV_TICK:   clk_1hz <= level;
            EV_TOGGLE: toggle  <= level;
            EV_MODE:   mode    <= level;
            default:   adjust  <= level;
        endcase
    endtask

    task automatic press(input event_e ev);
        @(posedge CLK_50);
        drive_input(ev, 1'b1);
        repeat (5) @(posedge CLK_50);
        drive_input(ev, 1'b0);
        repeat (5) @(posedge CLK_50);
    endtask

    task automatic apply_model(input event_e ev);
        m_time = next_time(m_time, m_setting, m_field, ev);
        if (ev == EV_MODE && m_setting) begin
            m_field = next_field(m_field);
        end else if (ev == EV_ADJUST) begin
            m_setting = !m_setting;
            m_field   = FIELD_HR;          // each setup session starts on hours.
        end
    endtask

    task automatic settle();
        for (int n = 0; n < SETTLE_CYCLES; n++) begin
            @(negedge CLK_50);
        end
    endtask

    task automatic request_check();
        int waited;
        waited = 0;
        req_count++;
        while (ack_count != req_count && waited < ACK_TIMEOUT) begin
            @(negedge CLK_50);
            waited++;
        end
        if (ack_count != req_count) begin
            fail_run("timeout while waiting for the compare process to answer");
        end
    endtask

    task automatic run_event(input event_e ev);
        press(ev);
        apply_model(ev);
        settle();
        request_check();
    endtask

    // Outputs are compared on the falling edge, away from the register updates.
    always @(negedge CLK_50) begin
        if (ack_count != req_count) begin
            check_time(m_time, cur_time);
            check_field(m_field, field);
            check_setting(m_setting, setting);
            check_segments(seg_ref(m_time), segments);
            ack_count = req_count;
        end
    end

    initial begin
        event_e    ev;
        time_bcd_t held;
        reset     = 1'b1;
        adjust    = 1'b0;
        mode      = 1'b0;
        toggle    = 1'b0;
        clk_1hz   = 1'b0;
        m_time    = RESET_TIME;
        m_field   = FIELD_HR;
        m_setting = 1'b0;
        repeat (2) @(posedge CLK_50);
        @(negedge CLK_50);
        check_segments({6{SEG_BLANK}}, segments);   // display is dark in reset.
        @(posedge CLK_50);
        reset <= 1'b0;
        settle();
        request_check();
        for (int i = 0; i < 3700; i++) begin
            run_event(EV_TICK);                     // crosses 12:59:59 into 1:00:00.
        end
        run_event(EV_ADJUST);
        check_setting(1'b1, setting);
        held = m_time;
        for (int i = 0; i < 3; i++) begin
            run_event(EV_TICK);
        end
        check_time(held, cur_time);
        run_event(EV_ADJUST);
        check_setting(1'b0, setting);
        check_field(FIELD_HR, field);
        run_event(EV_ADJUST);
        for (int i = 0; i < 4; i++) begin
            run_event(EV_MODE);
            check_field(FIELD_SEQ[i], field);
        end
        run_event(EV_MODE);
        run_event(EV_MODE);                         // back on hours.
        for (int i = 0; i < 12; i++) begin
            run_event(EV_TOGGLE);
        end
        run_event(EV_MODE);
        for (int i = 0; i < 59; i++) begin
            run_event(EV_TOGGLE);                   // minutes pass 59 to 00.
        end
        run_event(EV_MODE);
        run_event(EV_TOGGLE);
        run_event(EV_ADJUST);
        for (int i = 0; i < 400; i++) begin
            pick_event(ev);
            run_event(ev);
        end
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
clock_pkg.sv
input_sync.sv
field_select.sv
time_keeper.sv
digit_display.sv
clock_top.sv
tb_clock.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_clock
FILELIST  := sim.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG) for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "STATUS: PASS" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
